/* project.f */
trellisPkg.sv
symbolSlipControl.sv
sampleLatch.sv
trellisRegs.sv
dacMux.sv
trellisFrontEnd.sv
tbClockGen.sv
tbTrellisFrontEnd.sv

/* Makefile */
SOURCES := $(shell cat project.f)

all: run

obj_dir/VtbTrellisFrontEnd: project.f $(SOURCES)
	verilator --binary --assert --timing -f project.f --top-module tbTrellisFrontEnd \
		-o VtbTrellisFrontEnd

run: obj_dir/VtbTrellisFrontEnd
	./obj_dir/VtbTrellisFrontEnd

clean:
	rm -rf obj_dir

.PHONY: all run clean

/* tbTrellisFrontEnd.sv */
// testbench for the trellis front end
// reference model from the latency rules, immediate assertions, watchdog

`timescale 1ns/1ps

module tbTrellisFrontEnd import trellisPkg::*; ();

    localparam int resetCycles = 8;
    localparam int symbolCycles = 6;
    localparam int streamSymbols = 20;
    localparam int shortSymbols = 10;
    localparam int busCycles = 60;
    localparam int totalSymbols = 2 * streamSymbols + 5 * shortSymbols;
    localparam int timeoutNs =
        (resetCycles + totalSymbols * symbolCycles + busCycles) * 10 + 2000;
    localparam logic [addrWidth-1:0] decayAddr = {trellisSpaceBase, trellisDecayAddr};
    localparam logic [addrWidth-1:0] controlAddr = {trellisSpaceBase, trellisControlAddr};

    logic clk;
    logic symbolSlipped;
    logic signed [sampleWidth-1:0] iIn, qIn, iOut, qOut;
    logic signed [sampleWidth-1:0] dac0Data, dac1Data, dac2Data;
    logic symEnIn, sym2xEnIn, symEnOut, sym2xEnOut, wr, tbEnable;
    logic dac0ClkEn, dac1ClkEn, dac2ClkEn;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] din, dout;
    logic [dacSelWidth-1:0] dac0Select, dac1Select, dac2Select;
    logic [decayWidth-1:0] decayFactor;

    // stimulus history by age in cycles
    // suffix 1 means driven last cycle and 2 means two cycles ago
    logic sym1, sym2x1, sym2x2, wr1;
    logic signed [sampleWidth-1:0] i1, q1, i2, q2;
    logic [addrWidth-1:0] addr1;
    logic [dataWidth-1:0] din1;
    logic [dacSelWidth-1:0] sel1 [3];
    logic [dacSelWidth-1:0] dacSel [3];
    logic busWr;
    logic [addrWidth-1:0] busAddr;
    logic [dataWidth-1:0] busDin;

    // --------------------------------------------------
    // expected state
    // --------------------------------------------------
    logic signed [sampleWidth-1:0] expI, expQ, strobeI, strobeQ;
    logic expSym2x, delayModel, tbModel, slipMode, readPending;
    logic [decayWidth-1:0] decayModel;
    logic [dataWidth-1:0] readExp;
    int missed;

    tbClockGen u_clockGen (.clk(clk));

    trellisFrontEnd u_dut (.*);

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else
            failRun($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    task automatic checkOutputs();
        logic signed [sampleWidth-1:0] gotData [3];
        logic signed [sampleWidth-1:0] wantData [3];
        logic gotEn [3];
        logic wantEn [3];
        gotData = '{dac0Data, dac1Data, dac2Data};
        gotEn = '{dac0ClkEn, dac1ClkEn, dac2ClkEn};
        // DACs register last cycle's iOut/qOut and half-symbol strobe
        for (int ch = 0; ch < 3; ch++) begin
            wantData[ch] = '0;
            wantEn[ch] = 1'b0;
            if (sel1[ch] == dacSourceI) begin
                wantData[ch] = expI;
                wantEn[ch] = expSym2x;
            end
            else if (sel1[ch] == dacSourceQ) begin
                wantData[ch] = expQ;
                wantEn[ch] = expSym2x;
            end
        end
        // latch follows the strobe given two cycles ago
        if (sym2x2) begin
            expI = delayModel ? strobeI : i2;
            expQ = delayModel ? strobeQ : q2;
            strobeI = i2;
            strobeQ = q2;
        end
        expSym2x = sym2x1;
        if (wr1 && addr1 == decayAddr) begin
            decayModel = din1[decayWidth-1:0];
        end
        if (wr1 && addr1 == controlAddr) begin
            delayModel = din1[ctrlDelayBit];
            tbModel = din1[ctrlTbEnableBit];
        end
        checkValue("sym2xEnOut", 32'(sym2xEnOut), 32'(expSym2x));
        if (slipMode) begin
            assert (!(symEnOut && !sym1)) else
                failRun("symEnOut pulsed with no symEnIn pulse one cycle before");
            if (sym1 && !symEnOut) begin
                missed = missed + 1;
            end
        end
        else begin
            checkValue("symEnOut", 32'(symEnOut), 32'(sym1));
        end
        checkValue("iOut", 32'(iOut), 32'(expI));
        checkValue("qOut", 32'(qOut), 32'(expQ));
        checkValue("tbEnable", 32'(tbEnable), 32'(tbModel));
        checkValue("decayFactor", 32'(decayFactor), 32'(decayModel));
        for (int ch = 0; ch < 3; ch++) begin
            checkValue($sformatf("dac%0dData", ch), 32'(gotData[ch]), 32'(wantData[ch]));
            checkValue($sformatf("dac%0dClkEn", ch), 32'(gotEn[ch]), 32'(wantEn[ch]));
        end
        if (readPending) begin
            checkValue("dout", dout, readExp);
        end
    endtask

    // one clock of checking at the falling edge and driving the next inputs
    task automatic stepCycle(input logic symBit, input logic sym2xBit);
        logic [31:0] rnd;
        @(negedge clk);
        checkOutputs();
        sym2x2 = sym2x1;
        i2 = i1;
        q2 = q1;
        sym1 = symBit;
        sym2x1 = sym2xBit;
        rnd = $urandom();
        i1 = rnd[sampleWidth-1:0];
        rnd = $urandom();
        q1 = rnd[sampleWidth-1:0];
        sel1 = dacSel;
        wr1 = busWr;
        addr1 = busAddr;
        din1 = busDin;
        iIn = i1;
        qIn = q1;
        symEnIn = sym1;
        sym2xEnIn = sym2x1;
        wr = busWr;
        addr = busAddr;
        din = busDin;
        dac0Select = dacSel[0];
        dac1Select = dacSel[1];
        dac2Select = dacSel[2];
    endtask

    // symbol every 6 cycles and half-symbol strobe every 3
    task automatic runSymbols(input int symbols);
        for (int s = 0; s < symbols * symbolCycles; s++) begin
            stepCycle(s % symbolCycles == 0, s % 3 == 0);
        end
    endtask

    task automatic writeReg(input logic [addrWidth-1:0] a, input logic [dataWidth-1:0] d);
        busWr = 1'b1;
        busAddr = a;
        busDin = d;
        stepCycle(1'b0, 1'b0);
        busWr = 1'b0;
        stepCycle(1'b0, 1'b0);
    endtask

    task automatic readCheck(input logic [addrWidth-1:0] a, input logic [dataWidth-1:0] exp);
        busAddr = a;
        stepCycle(1'b0, 1'b0);
        readPending = 1'b1;
        readExp = exp;
        stepCycle(1'b0, 1'b0);
        readPending = 1'b0;
    endtask

    initial begin
        #(timeoutNs);
        failRun("watchdog timeout, the run did not finish in time");
    end

    initial begin
        void'($urandom(32'h2a173ef1));
        symbolSlipped = 1'b1;
        {iIn, qIn, symEnIn, sym2xEnIn, wr, addr, din} = '0;
        {dac0Select, dac1Select, dac2Select} = '0;
        {sym1, sym2x1, sym2x2, wr1, i1, q1, i2, q2, addr1, din1} = '0;
        {busWr, busAddr, busDin, readPending, readExp, slipMode} = '0;
        {expI, expQ, strobeI, strobeQ, expSym2x, delayModel, tbModel, decayModel} = '0;
        sel1 = '{default: '0};
        dacSel = '{default: '0};
        missed = 0;
        repeat (resetCycles) @(negedge clk);
        symbolSlipped = 1'b0;

        // registers after reset, readback, unmapped addresses
        readCheck(decayAddr, 32'h0);
        readCheck(controlAddr, 32'h0);
        writeReg(decayAddr, 32'hffff_ff5a);
        readCheck(decayAddr, 32'h5a);
        writeReg(controlAddr, 32'h4);
        readCheck(controlAddr, 32'h4);
        writeReg(13'h1a00, 32'h33);
        readCheck(decayAddr, 32'h5a);
        readCheck({trellisSpaceBase, 4'h8}, 32'h0);
        readCheck(13'h1a04, 32'h0);

        // strobes pass with no slip pending
        runSymbols(streamSymbols);

        // one slip request drops one symbol strobe
        writeReg(controlAddr, 32'h5);
        readCheck(controlAddr, 32'h5);
        slipMode = 1'b1;
        runSymbols(shortSymbols);
        slipMode = 1'b0;
        assert (missed == 1) else
            failRun($sformatf("slip request removed %0d symbol strobes instead of one", missed));
        readCheck(controlAddr, 32'h4);
        runSymbols(shortSymbols);

        // one-strobe sample delay
        writeReg(controlAddr, 32'h6);
        readCheck(controlAddr, 32'h6);
        runSymbols(streamSymbols);
        writeReg(controlAddr, 32'h4);

        // monitor DAC sources, off and unknown codes
        dacSel = '{dacSourceI, dacSourceQ, dacSourceOff};
        runSymbols(shortSymbols);
        dacSel = '{dacSourceQ, 4'hb, dacSourceI};
        runSymbols(shortSymbols);
        dacSel = '{4'hf, dacSourceI, dacSourceQ};
        runSymbols(shortSymbols);

        $display("Everything OK");
        $finish;
    end

endmodule

/* tbClockGen.sv */
// testbench clock source, 10 ns period

`timescale 1ns/1ps

module tbClockGen (
    output logic clk
);

    localparam int halfPeriodNs = 5;

    initial begin
        clk = 1'b0;
    end

    always #(halfPeriodNs) clk = ~clk;

endmodule

/* trellisFrontEnd.sv */
// multi-h trellis demodulator front end, top level
// slip control, sample latch, control registers and monitor DACs

`timescale 1ns/1ps

module trellisFrontEnd import trellisPkg::*; (
    input  logic                          clk,
    input  logic                          symbolSlipped,
    // sample stream
    input  logic signed [sampleWidth-1:0] iIn,
    input  logic signed [sampleWidth-1:0] qIn,
    input  logic                          symEnIn,
    input  logic                          sym2xEnIn,
    // register bus
    input  logic                          wr,
    input  logic [addrWidth-1:0]          addr,
    input  logic [dataWidth-1:0]          din,
    output logic [dataWidth-1:0]          dout,
    // monitor DACs
    input  logic [dacSelWidth-1:0]        dac0Select,
    input  logic [dacSelWidth-1:0]        dac1Select,
    input  logic [dacSelWidth-1:0]        dac2Select,
    output logic signed [sampleWidth-1:0] dac0Data,
    output logic signed [sampleWidth-1:0] dac1Data,
    output logic signed [sampleWidth-1:0] dac2Data,
    output logic                          dac0ClkEn,
    output logic                          dac1ClkEn,
    output logic                          dac2ClkEn,
    // to the decoder
    output logic [decayWidth-1:0]         decayFactor,
    output logic                          tbEnable,
    output logic signed [sampleWidth-1:0] iOut,
    output logic signed [sampleWidth-1:0] qOut,
    output logic                          symEnOut,
    output logic                          sym2xEnOut
);

    logic signed [sampleWidth-1:0] slipI;
    logic signed [sampleWidth-1:0] slipQ;
    logic                          symbolSlip;
    logic                          symbolDelay;
    logic                          slipTaken;

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    symbolSlipControl u_slipControl (
        .clk           (clk),
        .symbolSlipped (symbolSlipped),
        .iIn           (iIn),
        .qIn           (qIn),
        .symEnIn       (symEnIn),
        .sym2xEnIn     (sym2xEnIn),
        .symbolSlip    (symbolSlip),
        .slipI         (slipI),
        .slipQ         (slipQ),
        .symEn         (symEnOut),
        .sym2xEn       (sym2xEnOut),
        .slipTaken     (slipTaken)
    );

    sampleLatch u_sampleLatch (
        .clk           (clk),
        .symbolSlipped (symbolSlipped),
        .sym2xEn       (sym2xEnOut),
        .symbolDelay   (symbolDelay),
        .slipI         (slipI),
        .slipQ         (slipQ),
        .iOut          (iOut),
        .qOut          (qOut)
    );

    // control and monitors
    trellisRegs u_regs (
        .clk           (clk),
        .symbolSlipped (symbolSlipped),
        .wr            (wr),
        .addr          (addr),
        .din           (din),
        .dout          (dout),
        .slipTaken     (slipTaken),
        .symbolSlip    (symbolSlip),
        .symbolDelay   (symbolDelay),
        .tbEnable      (tbEnable),
        .decayFactor   (decayFactor)
    );

    dacMux u_dacMux (
        .clk           (clk),
        .symbolSlipped (symbolSlipped),
        .dac0Select    (dac0Select),
        .dac1Select    (dac1Select),
        .dac2Select    (dac2Select),
        .iOut          (iOut),
        .qOut          (qOut),
        .sym2xEn       (sym2xEnOut),
        .dac0Data      (dac0Data),
        .dac1Data      (dac1Data),
        .dac2Data      (dac2Data),
        .dac0ClkEn     (dac0ClkEn),
        .dac1ClkEn     (dac1ClkEn),
        .dac2ClkEn     (dac2ClkEn)
    );

endmodule

/* dacMux.sv */
// three registered monitor DAC channels
// each channel picks I, Q or off by its select code

`timescale 1ns/1ps

module dacMux import trellisPkg::*; (
    input  logic                          clk,
    input  logic                          symbolSlipped,
    input  logic [dacSelWidth-1:0]        dac0Select,
    input  logic [dacSelWidth-1:0]        dac1Select,
    input  logic [dacSelWidth-1:0]        dac2Select,
    input  logic signed [sampleWidth-1:0] iOut,
    input  logic signed [sampleWidth-1:0] qOut,
    input  logic                          sym2xEn,
    output logic signed [sampleWidth-1:0] dac0Data,
    output logic signed [sampleWidth-1:0] dac1Data,
    output logic signed [sampleWidth-1:0] dac2Data,
    output logic                          dac0ClkEn,
    output logic                          dac1ClkEn,
    output logic                          dac2ClkEn
);

    // --------------------------------------------------
    // source select, returns {clkEn, data}
    // --------------------------------------------------
    function automatic logic [sampleWidth:0] channelNext(
        input logic [dacSelWidth-1:0]        sel,
        input logic signed [sampleWidth-1:0] iSample,
        input logic signed [sampleWidth-1:0] qSample,
        input logic                          strobe
    );
        logic [sampleWidth:0] result;
        case (dacSourceT'(sel))
            dacSourceI: begin
                result = {strobe, iSample};
            end
            dacSourceQ: begin
                result = {strobe, qSample};
            end
            // off and unknown codes
            default: begin
                result = '0;
            end
        endcase
        return result;
    endfunction

    logic [sampleWidth:0] dac0Next;
    logic [sampleWidth:0] dac1Next;
    logic [sampleWidth:0] dac2Next;

    assign dac0Next = channelNext(dac0Select, iOut, qOut, sym2xEn);
    assign dac1Next = channelNext(dac1Select, iOut, qOut, sym2xEn);
    assign dac2Next = channelNext(dac2Select, iOut, qOut, sym2xEn);

    // output registers
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            dac0Data  <= '0;
            dac1Data  <= '0;
            dac2Data  <= '0;
            dac0ClkEn <= 1'b0;
            dac1ClkEn <= 1'b0;
            dac2ClkEn <= 1'b0;
        end
        else begin
            {dac0ClkEn, dac0Data} <= dac0Next;
            {dac1ClkEn, dac1Data} <= dac1Next;
            {dac2ClkEn, dac2Data} <= dac2Next;
        end
    end

endmodule

/* trellisRegs.sv */
// trellis control registers on the register bus
// decay factor, control bits, readback and self-clearing slip request

`timescale 1ns/1ps

module trellisRegs import trellisPkg::*; (
    input  logic                   clk,
    input  logic                   symbolSlipped,
    input  logic                   wr,
    input  logic [addrWidth-1:0]   addr,
    input  logic [dataWidth-1:0]   din,
    output logic [dataWidth-1:0]   dout,
    input  logic                   slipTaken,
    output logic                   symbolSlip,
    output logic                   symbolDelay,
    output logic                   tbEnable,
    output logic [decayWidth-1:0]  decayFactor
);

    logic                          trellisSpace;
    logic [trellisOffsetWidth-1:0] offset;
    logic                          decayWrite;
    logic                          ctrlWrite;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    assign trellisSpace = (addr[addrWidth-1:trellisOffsetWidth] == trellisSpaceBase);
    assign offset       = addr[trellisOffsetWidth-1:0];

    assign decayWrite = wr && trellisSpace && (offset == trellisDecayAddr);
    assign ctrlWrite  = wr && trellisSpace && (offset == trellisControlAddr);

    // decay factor and static control bits
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            decayFactor <= '0;
            symbolDelay <= 1'b0;
            tbEnable    <= 1'b0;
        end
        else begin
            if (decayWrite) begin
                decayFactor <= din[decayWidth-1:0];
            end
            if (ctrlWrite) begin
                symbolDelay <= din[ctrlDelayBit];
                tbEnable    <= din[ctrlTbEnableBit];
            end
        end
    end

    // slip request, cleared once the slip control has dropped a strobe
    // a fresh write in the same cycle still wins
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            symbolSlip <= 1'b0;
        end
        else if (ctrlWrite) begin
            symbolSlip <= din[ctrlSlipBit];
        end
        else if (slipTaken) begin
            symbolSlip <= 1'b0;
        end
    end

    // --------------------------------------------------
    // readback
    // --------------------------------------------------
    always_comb begin
        dout = '0;
        if (trellisSpace) begin
            case (offset)
                trellisDecayAddr: begin
                    dout[decayWidth-1:0] = decayFactor;
                end
                trellisControlAddr: begin
                    dout[ctrlSlipBit]     = symbolSlip;
                    dout[ctrlDelayBit]    = symbolDelay;
                    dout[ctrlTbEnableBit] = tbEnable;
                end
                default: begin
                    dout = '0;
                end
            endcase
        end
    end

endmodule

/* sampleLatch.sv */
// I/Q sample latch on the half-symbol strobe
// optional one-strobe delay for symbol alignment

`timescale 1ns/1ps

module sampleLatch import trellisPkg::*; (
    input  logic                          clk,
    input  logic                          symbolSlipped,
    input  logic                          sym2xEn,
    input  logic                          symbolDelay,
    input  logic signed [sampleWidth-1:0] slipI,
    input  logic signed [sampleWidth-1:0] slipQ,
    output logic signed [sampleWidth-1:0] iOut,
    output logic signed [sampleWidth-1:0] qOut
);

    // sample seen at the previous strobe
    logic signed [sampleWidth-1:0] iDelay;
    logic signed [sampleWidth-1:0] qDelay;

    // delay line runs on every strobe so toggling
    // symbolDelay never presents a stale sample
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            iDelay <= '0;
            qDelay <= '0;
        end
        else if (sym2xEn) begin
            iDelay <= slipI;
            qDelay <= slipQ;
        end
    end

    // --------------------------------------------------
    // output latch
    // --------------------------------------------------
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            iOut <= '0;
            qOut <= '0;
        end
        else if (sym2xEn) begin
            if (symbolDelay) begin
                iOut <= iDelay;
                qOut <= qDelay;
            end
            else begin
                iOut <= slipI;
                qOut <= slipQ;
            end
        end
    end

endmodule

/* symbolSlipControl.sv */
// input reclocking and symbol slip gating
// one slip request removes exactly one symbol strobe

`timescale 1ns/1ps

module symbolSlipControl import trellisPkg::*; (
    input  logic                          clk,
    input  logic                          symbolSlipped,
    input  logic signed [sampleWidth-1:0] iIn,
    input  logic signed [sampleWidth-1:0] qIn,
    input  logic                          symEnIn,
    input  logic                          sym2xEnIn,
    input  logic                          symbolSlip,
    output logic signed [sampleWidth-1:0] slipI,
    output logic signed [sampleWidth-1:0] slipQ,
    output logic                          symEn,
    output logic                          sym2xEn,
    output logic                          slipTaken
);

    // two-stage delay on the slip request
    logic [1:0] slipSR;
    logic       slip;

    assign slip = slipSR[1];

    // reclocked samples
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            slipI <= '0;
            slipQ <= '0;
        end
        else begin
            slipI <= iIn;
            slipQ <= qIn;
        end
    end

    // --------------------------------------------------
    // strobe reclock and gating
    // --------------------------------------------------
    always_ff @(posedge clk or posedge symbolSlipped) begin
        if (symbolSlipped) begin
            slipSR    <= '0;
            symEn     <= 1'b0;
            sym2xEn   <= 1'b0;
            slipTaken <= 1'b0;
        end
        else begin
            slipSR  <= {slipSR[0], symbolSlip};
            sym2xEn <= sym2xEnIn;

            // swallow this strobe and let the register bank drop the request
            if (symEnIn && slip) begin
                symEn     <= 1'b0;
                slipTaken <= 1'b1;
            end
            else begin
                symEn     <= symEnIn;
                slipTaken <= 1'b0;
            end
        end
    end

endmodule

/* trellisPkg.sv */
// shared widths, trellis register map and DAC source codes
// for the multi-h trellis demodulator front end

package trellisPkg;

    // --------------------------------------------------
    // datapath and bus widths
    // --------------------------------------------------
    localparam int sampleWidth = 18;
    localparam int addrWidth   = 13;
    localparam int dataWidth   = 32;
    localparam int decayWidth  = 8;

    // --------------------------------------------------
    // register map
    // --------------------------------------------------
    // low address bits select a register inside trellis space
    localparam int trellisOffsetWidth = 4;

    // trellis space is 0x0a00 to 0x0a0f
    localparam logic [addrWidth-1:trellisOffsetWidth] trellisSpaceBase = 9'h0a0;

    localparam logic [trellisOffsetWidth-1:0] trellisDecayAddr   = 4'h0;
    localparam logic [trellisOffsetWidth-1:0] trellisControlAddr = 4'h4;

    // control register fields
    localparam int ctrlSlipBit     = 0;
    localparam int ctrlDelayBit    = 1;
    localparam int ctrlTbEnableBit = 2;

    // --------------------------------------------------
    // monitor DAC sources
    // --------------------------------------------------
    localparam int dacSelWidth = 4;

    // codes not listed here behave as off
    typedef enum logic [dacSelWidth-1:0] {
        dacSourceOff = 4'd0,
        dacSourceI   = 4'd1,
        dacSourceQ   = 4'd2
    } dacSourceT;

endpackage
